// ==== dv/tb_dz_countdown.sv ====
`timescale 1ns/10ps

module tb_dz_countdown import dz_pkg::*; ();

    localparam int SCAN_DIV        = 4;
    localparam int FRAMES_PER_STEP = 2;
    localparam int START_DIGIT     = 5;
    localparam int CLK_PERIOD      = 8;
    localparam int RUNS            = 12;
    localparam int HOLD_MAX        = 40;  // cycles req stays high after ack
    localparam int GAP_MAX         = 30;  // idle cycles between runs
    localparam int DWELL           = ROWS * FRAMES_PER_STEP;

    localparam int RUN_CYCLES = START_DIGIT * DWELL * SCAN_DIV + SCAN_DIV
                              + HOLD_MAX + GAP_MAX + 8;
    localparam int TIMEOUT_CYCLES = 3 + 3 * ROWS * SCAN_DIV + RUNS * RUN_CYCLES + 100;

    logic       clk;
    logic       rst;
    logic       start_req;
    logic       start_ack;
    logic [7:0] row;
    logic [7:0] colr;
    logic [7:0] colg;

    logic [31:0] lcg_state;

    // frame model state
    logic [7:0] row_prev;
    logic [7:0] colr_prev;
    logic [7:0] colg_prev;
    int         cyc;
    int         last_tick;
    int         exp_ridx;
    int         shown_digit;
    int         dwell_ticks;
    int         runs_done;
    bit         have_tick;
    bit         shown_blank;
    bit         ack_exp;
    cd_state_t  model_state;

    dz_countdown_top
    #(
        .SCAN_DIV        (SCAN_DIV),
        .FRAMES_PER_STEP (FRAMES_PER_STEP),
        .START_DIGIT     (START_DIGIT)
    )
    i_dz_countdown_top
    (
        .clk       (clk),
        .rst       (rst),
        .start_req (start_req),
        .start_ack (start_ack),
        .row       (row),
        .colr      (colr),
        .colg      (colg)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // glyph rows packed top row first
    function automatic logic [7:0] font_row(input int digit, input int r);
        logic [63:0] glyph;
        case (digit)
            5: glyph = 64'h7E60_7C06_0666_3C00;
            4: glyph = 64'h0C1C_2C4C_7E0C_0C00;
            3: glyph = 64'h3C66_061C_0666_3C00;
            2: glyph = 64'h003C_6606_0C30_607E;
            1: glyph = 64'h0018_1838_1818_187E;
            0: glyph = 64'h003C_4242_4242_423C;
            default: glyph = '0;
        endcase
        return glyph[63 - 8 * r -: 8];
    endfunction

    // 5 and 4 red, 3 and 2 yellow, 1 and 0 green
    function automatic logic [7:0] expect_col(input int digit, input int r, input bit red_bus);
        logic lit;
        case (digit)
            5, 4:    lit = red_bus;
            3, 2:    lit = 1'b1;
            1, 0:    lit = !red_bus;
            default: lit = 1'b0;
        endcase
        return lit ? font_row(digit, r) : 8'h00;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual)
        begin
            $display("Fail at %0t ns: %s expected 'h%0h, got 'h%0h",
                     $time, name, expected, actual);
            $display("Test failures found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // outputs sampled on the falling edge where start_req is what the DUT saw
    always @(negedge clk)
    begin : frame_monitor
        logic       tick;
        logic [7:0] exp_row;
        if (rst)
        begin
            check_value("start_ack", 0, int'(start_ack));
            check_value("row", 'hff, int'(row));
            check_value("colr", 0, int'(colr));
            check_value("colg", 0, int'(colg));
            row_prev    = 8'hff;
            colr_prev   = 8'h00;
            colg_prev   = 8'h00;
            cyc         = 0;
            last_tick   = 0;
            exp_ridx    = 0;
            shown_digit = 0;
            dwell_ticks = 0;
            runs_done   = 0;
            have_tick   = 1'b0;
            shown_blank = 1'b1;
            ack_exp     = 1'b0;
            model_state = CD_IDLE;
        end
        else
        begin
            cyc  = cyc + 1;
            tick = (row !== row_prev);
            if (tick)
            begin
                if (have_tick)
                    check_value("row tick spacing", SCAN_DIV, cyc - last_tick);
                have_tick = 1'b1;
                last_tick = cyc;
                exp_row   = ~(8'd1 << exp_ridx);
                check_value("row", int'(exp_row), int'(row));
                check_value("colr",
                            shown_blank ? 0 : int'(expect_col(shown_digit, exp_ridx, 1'b1)),
                            int'(colr));
                check_value("colg",
                            shown_blank ? 0 : int'(expect_col(shown_digit, exp_ridx, 1'b0)),
                            int'(colg));
                exp_ridx = (exp_ridx + 1) % ROWS;
            end
            else
            begin
                check_value("colr", int'(colr_prev), int'(colr));  // only moves with row
                check_value("colg", int'(colg_prev), int'(colg));
            end
            case (model_state)
                CD_IDLE:
                begin
                    if (start_req)
                    begin
                        model_state = CD_COUNT;
                        shown_digit = START_DIGIT;
                        shown_blank = 1'b0;
                        dwell_ticks = 0;
                    end
                end
                CD_COUNT:
                begin
                    if (tick)
                    begin
                        dwell_ticks = dwell_ticks + 1;
                        if (dwell_ticks == DWELL)
                        begin
                            dwell_ticks = 0;
                            shown_digit = shown_digit - 1;
                            if (shown_digit == 0)
                            begin
                                model_state = CD_DONE;
                                ack_exp     = 1'b1;
                                runs_done   = runs_done + 1;
                            end
                        end
                    end
                end
                CD_DONE:
                begin
                    if (!start_req)
                    begin
                        model_state = CD_IDLE;
                        ack_exp     = 1'b0;
                        shown_blank = 1'b1;
                    end
                end
                default:
                begin
                    model_state = CD_IDLE;
                end
            endcase
            check_value("start_ack", int'(ack_exp), int'(start_ack));
            row_prev  = row;
            colr_prev = colr;
            colg_prev = colg;
        end
    end

    initial
    begin : host_driver
        int hold;
        int gap;
        lcg_state = 32'h3ac0cfb9;
        rst       <= 1'b1;
        start_req <= 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;
        repeat (ROWS * SCAN_DIV) @(negedge clk);  // one blank frame first
        for (int run = 0; run < RUNS; run++)
        begin
            start_req <= 1'b1;
            @(negedge clk);
            while (!start_ack)
                @(negedge clk);
            hold = int'(next_rand() >> 16) % (HOLD_MAX + 1);
            repeat (hold) @(negedge clk);
            start_req <= 1'b0;
            @(negedge clk);
            while (start_ack)
                @(negedge clk);
            gap = int'(next_rand() >> 16) % (GAP_MAX + 1);
            repeat (gap) @(negedge clk);
        end
        repeat (2 * ROWS * SCAN_DIV) @(negedge clk);  // blank tail
        check_value("completed runs", RUNS, runs_done);
        $display("All tests passed!");
        $finish;
    end

    initial
    begin : watchdog
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the countdown runs did not finish within %0d cycles",
                 TIMEOUT_CYCLES);
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== dz_countdown.f ====
src/dz_pkg.sv
src/dz_scan_if.sv
src/dz_countdown.sv
src/dz_glyph_rom.sv
src/dz_matrix_scan.sv
src/dz_countdown_top.sv
dv/tb_dz_countdown.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the countdown testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

top=tb_dz_countdown
build_dir=obj_dir
build_log=build.log
log=sim.log
fail_msg="Test failures found"

verilator --binary --timing --assert -f dz_countdown.f --top-module "$top" \
    -Mdir "$build_dir" -o "$top" > "$build_log" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    cat "$build_log"
    echo "verilator build failed with status $build_status"
    exit 1
fi

"./$build_dir/$top" > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "$fail_msg" "$log"; then
    echo "simulation reported failures, see $log"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

echo "simulation finished cleanly"
exit 0

// ==== src/dz_countdown.sv ====
`timescale 1ns/10ps

module dz_countdown import dz_pkg::*;
#(
    parameter int FRAMES_PER_STEP = 1,
    parameter int START_DIGIT     = 5
)
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start_req,
    output logic      start_ack,
    dz_scan_if.ctrl   sif
);

    // row ticks per digit
    localparam int DWELL = ROWS * FRAMES_PER_STEP;
    localparam int DW    = $clog2(DWELL);

    cd_state_t         state;
    logic [DW-1:0]     dwell_cnt;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state     <= CD_IDLE;
            sif.digit <= '0;
            sif.blank <= 1'b1;
            start_ack <= 1'b0;
            dwell_cnt <= '0;
        end
        else
        begin
            case (state)
                CD_IDLE:
                begin
                    if (start_req && !start_ack)
                    begin
                        state     <= CD_COUNT;
                        sif.digit <= digit_t'(START_DIGIT);
                        sif.blank <= 1'b0;
                        dwell_cnt <= '0;
                    end
                end
                CD_COUNT:
                begin
                    if (sif.row_tick)
                    begin
                        if (dwell_cnt == DW'(DWELL - 1))
                        begin
                            dwell_cnt <= '0;
                            sif.digit <= sif.digit - digit_t'(1);
                            // stepping 1 -> 0 ends the count
                            if (sif.digit == digit_t'(1))
                            begin
                                state     <= CD_DONE;
                                start_ack <= 1'b1;
                            end
                        end
                        else
                        begin
                            dwell_cnt <= dwell_cnt + DW'(1);
                        end
                    end
                end
                CD_DONE:
                begin
                    if (!start_req)  // host released so blank and drop ack
                    begin
                        state     <= CD_IDLE;
                        start_ack <= 1'b0;
                        sif.blank <= 1'b1;
                    end
                end
                default:
                begin
                    state <= CD_IDLE;
                end
            endcase
        end
    end

    a_ack_only_done: assert property (@(posedge clk) disable iff (rst)
        start_ack |-> (state == CD_DONE))
        else $error("start_ack high outside CD_DONE");

    a_digit_range: assert property (@(posedge clk) disable iff (rst)
        sif.digit <= digit_t'(START_DIGIT))
        else $error("digit above START_DIGIT");

    // digit moves only by one step down or a fresh load
    a_digit_step: assert property (@(posedge clk) disable iff (rst)
        $changed(sif.digit) |->
            (sif.digit == digit_t'($past(sif.digit) - digit_t'(1))) ||
            (sif.digit == digit_t'(START_DIGIT)))
        else $error("digit jumped");

endmodule

// ==== src/dz_countdown_top.sv ====
`timescale 1ns/10ps

module dz_countdown_top import dz_pkg::*;
#(
    parameter int SCAN_DIV        = 4,
    parameter int FRAMES_PER_STEP = 2,
    parameter int START_DIGIT     = 5
)
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start_req,
    output logic      start_ack,
    output row_bits_t row,
    output col_bits_t colr,
    output col_bits_t colg
);

    dz_scan_if sif ();

    dz_countdown
    #(
        .FRAMES_PER_STEP (FRAMES_PER_STEP),
        .START_DIGIT     (START_DIGIT)
    )
    i_dz_countdown
    (
        .clk       (clk),
        .rst       (rst),
        .start_req (start_req),
        .start_ack (start_ack),
        .sif       (sif.ctrl)
    );

    dz_glyph_rom i_dz_glyph_rom
    (
        .sif (sif.rom)
    );

    dz_matrix_scan
    #(
        .SCAN_DIV (SCAN_DIV)
    )
    i_dz_matrix_scan
    (
        .clk  (clk),
        .rst  (rst),
        .row  (row),
        .colr (colr),
        .colg (colg),
        .sif  (sif.scan)
    );

endmodule

// ==== src/dz_glyph_rom.sv ====
`timescale 1ns/10ps

module dz_glyph_rom import dz_pkg::*;
(
    dz_scan_if.rom sif
);

    col_bits_t pat;  // glyph row before colour gating

    always_comb
    begin
        pat = '0;
        case (sif.digit)
            3'd5:
            begin
                case (sif.row_idx)
                    3'd0: pat = 8'b0111_1110;
                    3'd1: pat = 8'b0110_0000;
                    3'd2: pat = 8'b0111_1100;
                    3'd3: pat = 8'b0000_0110;
                    3'd4: pat = 8'b0000_0110;
                    3'd5: pat = 8'b0110_0110;
                    3'd6: pat = 8'b0011_1100;
                    default: pat = '0;
                endcase
            end
            3'd4:
            begin
                case (sif.row_idx)
                    3'd0: pat = 8'b0000_1100;
                    3'd1: pat = 8'b0001_1100;
                    3'd2: pat = 8'b0010_1100;
                    3'd3: pat = 8'b0100_1100;
                    3'd4: pat = 8'b0111_1110;
                    3'd5: pat = 8'b0000_1100;
                    3'd6: pat = 8'b0000_1100;
                    default: pat = '0;
                endcase
            end
            3'd3:
            begin
                case (sif.row_idx)
                    3'd0: pat = 8'b0011_1100;
                    3'd1: pat = 8'b0110_0110;
                    3'd2: pat = 8'b0000_0110;
                    3'd3: pat = 8'b0001_1100;  // middle stroke
                    3'd4: pat = 8'b0000_0110;
                    3'd5: pat = 8'b0110_0110;
                    3'd6: pat = 8'b0011_1100;
                    default: pat = '0;
                endcase
            end
            3'd2:
            begin
                case (sif.row_idx)
                    3'd1: pat = 8'b0011_1100;
                    3'd2: pat = 8'b0110_0110;
                    3'd3: pat = 8'b0000_0110;
                    3'd4: pat = 8'b0000_1100;
                    3'd5: pat = 8'b0011_0000;
                    3'd6: pat = 8'b0110_0000;
                    3'd7: pat = 8'b0111_1110;
                    default: pat = '0;
                endcase
            end
            3'd1:
            begin
                case (sif.row_idx)
                    3'd0: pat = '0;
                    3'd3: pat = 8'b0011_1000;
                    3'd7: pat = 8'b0111_1110;
                    default: pat = 8'b0001_1000;
                endcase
            end
            3'd0:
            begin
                case (sif.row_idx)
                    3'd0: pat = '0;
                    3'd1: pat = 8'b0011_1100;
                    3'd7: pat = 8'b0011_1100;
                    default: pat = 8'b0100_0010;
                endcase
            end
            default:
            begin
                pat = '0;  // out of range stays dark
            end
        endcase
    end

    // red for 2..5, green for 0..3, both gives yellow
    assign sif.colr = (sif.digit >= digit_t'(2) && sif.digit <= digit_t'(5)) ? pat : '0;
    assign sif.colg = (sif.digit <= digit_t'(3)) ? pat : '0;

    always_comb
    begin
        a_digit_known: assert ($isunknown(sif.digit) || sif.digit <= digit_t'(5))
            else $error("glyph ROM got digit %0d", sif.digit);
    end

endmodule

// ==== src/dz_matrix_scan.sv ====
`timescale 1ns/10ps

module dz_matrix_scan import dz_pkg::*;
#(
    parameter int SCAN_DIV = 2
)
(
    input  logic      clk,
    input  logic      rst,
    output row_bits_t row,
    output col_bits_t colr,
    output col_bits_t colg,
    dz_scan_if.scan   sif
);

    localparam int PW = $clog2(SCAN_DIV);

    logic [PW-1:0] pre_cnt;

    // free running prescaler
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pre_cnt <= '0;
        end
        else if (pre_cnt == PW'(SCAN_DIV - 1))
        begin
            pre_cnt <= '0;
        end
        else
        begin
            pre_cnt <= pre_cnt + PW'(1);
        end
    end

    assign sif.row_tick = (pre_cnt == PW'(SCAN_DIV - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sif.row_idx <= '0;
            row         <= '1;  // all rows off
            colr        <= '0;
            colg        <= '0;
        end
        else if (sif.row_tick)
        begin
            // row and columns latched together for the same row_idx
            row  <= ~(row_bits_t'(1) << sif.row_idx);
            colr <= sif.blank ? '0 : sif.colr;
            colg <= sif.blank ? '0 : sif.colg;
            if (sif.row_idx == row_idx_t'(ROWS - 1))
            begin
                sif.row_idx <= '0;
            end
            else
            begin
                sif.row_idx <= sif.row_idx + row_idx_t'(1);
            end
        end
    end

    // once scanning starts there is always exactly one active row
    a_row_onehot: assert property (@(posedge clk) disable iff (rst)
        (row != '1) |=> $onehot(~row))
        else $error("row not one-hot low");

    // a full row period of blank leaves the columns dark
    a_blank_cols: assert property (@(posedge clk) disable iff (rst)
        (sif.blank && $past(sif.blank, SCAN_DIV)) |-> (colr == '0 && colg == '0))
        else $error("columns lit while blank");

endmodule

// ==== src/dz_pkg.sv ====
package dz_pkg;

    // matrix geometry
    localparam int ROWS = 8;

    // displayed digit, 0 to 5
    typedef logic [2:0] digit_t;

    // row currently being scanned
    typedef logic [2:0] row_idx_t;

    // row lines, active low, bit n drives row n
    typedef logic [7:0] row_bits_t;

    // one colour's column lines, active high
    typedef logic [7:0] col_bits_t;

    // countdown controller states
    typedef enum logic [1:0]
    {
        CD_IDLE  = 2'd0,  // blank, waiting for start_req
        CD_COUNT = 2'd1,  // stepping digits down
        CD_DONE  = 2'd2   // showing 0, ack high
    } cd_state_t;

endpackage

// ==== src/dz_scan_if.sv ====
`timescale 1ns/10ps

interface dz_scan_if import dz_pkg::*; ();

    digit_t    digit;     // digit on display
    logic      blank;     // columns off
    logic      row_tick;  // one cycle per row step
    row_idx_t  row_idx;   // row being looked up
    col_bits_t colr;      // red pattern for row_idx
    col_bits_t colg;      // green pattern for row_idx

    modport ctrl
    (
        output digit,
        output blank,
        input  row_tick
    );

    modport scan
    (
        output row_tick,
        output row_idx,
        input  colr,
        input  colg,
        input  blank
    );

    modport rom
    (
        input  digit,
        input  row_idx,
        output colr,
        output colg
    );

endinterface
